/* build.f */
source/framer_pkg.sv
source/block_loader.sv
source/block_fifo.sv
source/block_serializer.sv
source/block_framer.sv
tb/clock_gen.sv
tb/block_framer_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f \
    --top-module block_framer_tb -o block_framer_sim

output=$(./obj_dir/block_framer_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Everything OK"; then
    exit 0
fi
exit 1

/* source/block_fifo.sv */
`timescale 1ns/1ps

module block_fifo (
    input  logic               clk,
    input  logic               rst,
    input  framer_pkg::block_t in_block,
    input  logic               push,
    input  logic               pop,
    output logic               full,
    output framer_pkg::block_t out_block,
    output logic               not_empty
);
    import framer_pkg::*;

    block_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_block;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign out_block = mem[rd_ptr];

    // --------------------------------------------------
    // Handshake checks against loader and serializer
    // --------------------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("block pushed into a full FIFO");

    assert property (@(posedge clk) disable iff (rst)
        pop |-> not_empty)
        else $error("block popped from an empty FIFO");

endmodule

/* source/block_framer.sv */
`timescale 1ns/1ps

module block_framer (
    input  logic                  clk,
    input  logic                  rst,
    input  framer_pkg::word_t     bdi,
    input  logic                  bdi_valid,
    output logic                  bdi_ready,
    input  framer_pkg::bytes_t    bdi_valid_bytes,
    input  framer_pkg::bytes_t    bdi_pad_loc,
    input  logic                  bdi_eot,
    input  logic                  bdi_eoi,
    input  framer_pkg::seg_type_t bdi_type,
    output framer_pkg::word_t     bdo,
    output logic                  bdo_valid,
    input  logic                  bdo_ready,
    output framer_pkg::bytes_t    bdo_valid_bytes,
    output framer_pkg::dsinfo_t   bdo_dsinfo,
    output logic                  end_of_block
);
    import framer_pkg::*;

    block_t in_block;
    block_t out_block;
    logic   push;
    logic   pop;
    logic   full;
    logic   not_empty;

    block_loader u_loader (
        .clk             (clk),
        .rst             (rst),
        .bdi             (bdi),
        .bdi_valid       (bdi_valid),
        .bdi_ready       (bdi_ready),
        .bdi_valid_bytes (bdi_valid_bytes),
        .bdi_pad_loc     (bdi_pad_loc),
        .bdi_eot         (bdi_eot),
        .bdi_eoi         (bdi_eoi),
        .bdi_type        (bdi_type),
        .full            (full),
        .in_block        (in_block),
        .push            (push)
    );

    block_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_block  (in_block),
        .push      (push),
        .pop       (pop),
        .full      (full),
        .out_block (out_block),
        .not_empty (not_empty)
    );

    block_serializer u_serializer (
        .clk             (clk),
        .rst             (rst),
        .out_block       (out_block),
        .not_empty       (not_empty),
        .pop             (pop),
        .bdo             (bdo),
        .bdo_valid       (bdo_valid),
        .bdo_ready       (bdo_ready),
        .bdo_valid_bytes (bdo_valid_bytes),
        .bdo_dsinfo      (bdo_dsinfo),
        .end_of_block    (end_of_block)
    );

endmodule

/* source/block_loader.sv */
`timescale 1ns/1ps

module block_loader (
    input  logic                  clk,
    input  logic                  rst,
    input  framer_pkg::word_t     bdi,
    input  logic                  bdi_valid,
    output logic                  bdi_ready,
    input  framer_pkg::bytes_t    bdi_valid_bytes,
    input  framer_pkg::bytes_t    bdi_pad_loc,
    input  logic                  bdi_eot,
    input  logic                  bdi_eoi,
    input  framer_pkg::seg_type_t bdi_type,
    input  logic                  full,
    output framer_pkg::block_t    in_block,
    output logic                  push
);
    import framer_pkg::*;

    typedef enum logic [1:0] {
        S_LOAD,
        S_PAD_FULL,
        S_PAD,
        S_HOLD
    } state_t;

    state_t                state;
    state_t                state_nxt;
    word_idx_t             cnt;
    logic                  accept;
    logic                  shift;
    logic                  block_done;
    bytes_t                vbytes_sel;
    bytes_t                pad_loc_sel;
    word_t                 pad_word;
    dsinfo_t               dsinfo;

    logic [BLOCK_BITS-1:0] data_q;
    word_idx_t             last_word_q;
    bytes_t                last_bytes_q;
    logic                  eot_q;
    logic                  eoi_q;
    logic                  pad_q;
    seg_type_t             type_q;

    assign accept     = bdi_valid && bdi_ready;
    assign shift      = accept || (state == S_PAD_FULL) || (state == S_PAD);
    assign block_done = (cnt == word_idx_t'(BLOCK_WORDS - 1));
    assign push       = (state == S_HOLD) && !full;

    // --------------------------------------------------
    // Padding
    // --------------------------------------------------
    always_comb begin
        case (state)
            S_PAD_FULL: begin
                vbytes_sel  = '0;
                pad_loc_sel = {1'b1, {(CCW_BYTES-1){1'b0}}};
            end
            S_PAD: begin
                vbytes_sel  = '0;
                pad_loc_sel = '0;
            end
            default: begin
                vbytes_sel  = bdi_valid_bytes;
                pad_loc_sel = bdi_pad_loc;
            end
        endcase
    end

    // Lane 0 is the first byte, in the top of the word
    always_comb begin
        for (int i = 0; i < CCW_BYTES; i++) begin
            if (pad_loc_sel[CCW_BYTES-1-i])
                pad_word[CCW-8*(i+1) +: 8] = 8'h01;
            else if (vbytes_sel[CCW_BYTES-1-i])
                pad_word[CCW-8*(i+1) +: 8] = bdi[CCW-8*(i+1) +: 8];
            else
                pad_word[CCW-8*(i+1) +: 8] = 8'h00;
        end
    end

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            S_LOAD: begin
                if (accept) begin
                    if (block_done)
                        state_nxt = S_HOLD;
                    else if (!bdi_valid_bytes[0])
                        state_nxt = S_PAD;
                    else if (bdi_eot)
                        state_nxt = S_PAD_FULL;
                end
            end
            S_PAD_FULL: begin
                state_nxt = block_done ? S_HOLD : S_PAD;
            end
            S_PAD: begin
                if (block_done)
                    state_nxt = S_HOLD;
            end
            default: begin
                if (!full)
                    state_nxt = S_LOAD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_LOAD;
            cnt       <= '0;
            bdi_ready <= 1'b0;
        end else begin
            state     <= state_nxt;
            bdi_ready <= (state_nxt == S_LOAD);
            if (shift)
                cnt <= cnt + 1'b1;
        end
    end

    // Block register and the fields of the last data word
    always_ff @(posedge clk) begin
        if (shift)
            data_q <= {data_q[BLOCK_BITS-CCW-1:0], pad_word};
        if (accept) begin
            last_word_q  <= cnt;
            last_bytes_q <= bdi_valid_bytes;
            eot_q        <= bdi_eot;
            eoi_q        <= bdi_eoi;
            type_q       <= bdi_type;
            pad_q        <= !bdi_valid_bytes[0] || (bdi_eot && !block_done);
        end
    end

    always_comb begin
        dsinfo = '0;
        if (eot_q) begin
            dsinfo.domain     = domain_of(type_q);
            dsinfo.final_flag = eoi_q;
            dsinfo.pad        = pad_q;
        end
    end

    assign in_block.data       = data_q;
    assign in_block.last_word  = last_word_q;
    assign in_block.last_bytes = last_bytes_q;
    assign in_block.eot        = eot_q;
    assign in_block.dsinfo     = dsinfo;

    // A short word must close its segment
    assert property (@(posedge clk) disable iff (rst)
        accept && !bdi_valid_bytes[0] |-> bdi_eot)
        else $error("short input word without end of segment");

endmodule

/* source/block_serializer.sv */
`timescale 1ns/1ps

module block_serializer (
    input  logic                clk,
    input  logic                rst,
    input  framer_pkg::block_t  out_block,
    input  logic                not_empty,
    output logic                pop,
    output framer_pkg::word_t   bdo,
    output logic                bdo_valid,
    input  logic                bdo_ready,
    output framer_pkg::bytes_t  bdo_valid_bytes,
    output framer_pkg::dsinfo_t bdo_dsinfo,
    output logic                end_of_block
);
    import framer_pkg::*;

    logic [BLOCK_BITS-1:0] shift_q;
    word_idx_t             words_left;
    bytes_t                last_bytes_q;
    logic                  eot_q;
    dsinfo_t               dsinfo_q;
    logic                  is_last;
    logic                  take;

    assign is_last = (words_left == '0);
    assign take    = bdo_valid && bdo_ready;

    // Next block may be taken while the last word goes out
    assign pop = not_empty && (!bdo_valid || (take && is_last));

    always_ff @(posedge clk) begin
        if (rst) begin
            bdo_valid  <= 1'b0;
            words_left <= '0;
        end else if (pop) begin
            bdo_valid  <= 1'b1;
            words_left <= out_block.last_word;
        end else if (take) begin
            if (is_last)
                bdo_valid <= 1'b0;
            else
                words_left <= words_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q      <= out_block.data;
            last_bytes_q <= out_block.last_bytes;
            eot_q        <= out_block.eot;
            dsinfo_q     <= out_block.dsinfo;
        end else if (take) begin
            shift_q <= shift_q << CCW;
        end
    end

    // --------------------------------------------------
    // Output word and sideband
    // --------------------------------------------------
    assign bdo             = shift_q[BLOCK_BITS-1 -: CCW];
    assign bdo_valid_bytes = (is_last && eot_q) ? last_bytes_q : '1;
    assign bdo_dsinfo      = is_last ? dsinfo_q : '0;
    assign end_of_block    = bdo_valid && is_last;

    // Back-pressure holds the word and its sideband
    assert property (@(posedge clk) disable iff (rst)
        bdo_valid && !bdo_ready |=> bdo_valid && $stable(bdo)
            && $stable(bdo_valid_bytes) && $stable(end_of_block))
        else $error("bdo changed while stalled");

endmodule

/* source/framer_pkg.sv */
package framer_pkg;

    // --------------------------------------------------
    // Widths and depths
    // --------------------------------------------------
    localparam int CCW         = 32;
    localparam int CCW_BYTES   = CCW / 8;
    localparam int BLOCK_BITS  = 128;
    localparam int BLOCK_WORDS = BLOCK_BITS / CCW;
    localparam int WORD_IDX_W  = $clog2(BLOCK_WORDS);
    localparam int FIFO_DEPTH  = 2;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

    typedef logic [CCW-1:0]        word_t;
    typedef logic [CCW_BYTES-1:0]  bytes_t;
    typedef logic [3:0]            seg_type_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [1:0]            domain_t;

    // Segment type codes
    localparam seg_type_t HDR_AD       = 4'b0001;
    localparam seg_type_t HDR_PT       = 4'b0100;
    localparam seg_type_t HDR_CT       = 4'b0101;
    localparam seg_type_t HDR_HASH_MSG = 4'b0111;
    localparam seg_type_t HDR_TAG      = 4'b1000;
    localparam seg_type_t HDR_NPUB     = 4'b1101;

    localparam domain_t DOMAIN_NPUB  = 2'd1;
    localparam domain_t DOMAIN_AD    = 2'd2;
    localparam domain_t DOMAIN_OTHER = 2'd3;

    typedef struct packed {
        domain_t domain;
        logic    final_flag;
        logic    pad;
    } dsinfo_t;

    // First input word sits in the top 32 bits of data
    typedef struct packed {
        logic [BLOCK_BITS-1:0] data;
        word_idx_t             last_word;
        bytes_t                last_bytes;
        logic                  eot;
        dsinfo_t               dsinfo;
    } block_t;

    function automatic domain_t domain_of(seg_type_t seg_type);
        domain_t d;
        case (seg_type)
            HDR_NPUB:                 d = DOMAIN_NPUB;
            HDR_AD, HDR_HASH_MSG:     d = DOMAIN_AD;
            HDR_PT, HDR_CT, HDR_TAG:  d = DOMAIN_OTHER;
            default:                  d = DOMAIN_OTHER;
        endcase
        return d;
    endfunction

endpackage

/* tb/block_framer_tb.sv */
`timescale 1ns/1ps

module block_framer_tb;
    import framer_pkg::*;

    localparam logic [31:0] SEED = 32'h8f81_8749;
    localparam int NUM_ROWS     = 10;
    localparam int STALL_FACTOR = 8;
    localparam int OVERHEAD     = 200;

    typedef struct {
        seg_type_t seg_type;
        int        len;
        logic      eoi;
        logic      stall;
        int        blocks;
    } row_t;

    typedef struct packed {
        word_t     data;
        bytes_t    valid_bytes;
        bytes_t    pad_loc;
        logic      eot;
        logic      eoi;
        seg_type_t seg_type;
    } in_word_t;

    typedef struct packed {
        word_t   data;
        bytes_t  mask;
        dsinfo_t dsinfo;
        logic    eob;
    } exp_word_t;

    logic      clk;
    logic      rst;
    word_t     bdi;
    logic      bdi_valid;
    logic      bdi_ready;
    bytes_t    bdi_valid_bytes;
    bytes_t    bdi_pad_loc;
    logic      bdi_eot;
    logic      bdi_eoi;
    seg_type_t bdi_type;
    word_t     bdo;
    logic      bdo_valid;
    logic      bdo_ready = 1'b0;
    bytes_t    bdo_valid_bytes;
    dsinfo_t   bdo_dsinfo;
    logic      end_of_block;

    row_t        rows [NUM_ROWS];
    in_word_t    in_q [$];
    exp_word_t   exp_q [$];
    exp_word_t   head;
    logic [31:0] data_rng  = SEED;
    logic [31:0] stall_rng = ~SEED;
    logic [31:0] ready_rng = {SEED[15:0], SEED[31:16]};
    logic        ready_stall = 1'b0;
    int          check_errors = 0;
    int          other_errors = 0;
    int          blocks_seen = 0;
    int          blocks_expected = 0;
    int          total_bytes = 0;
    int          cycles = 0;
    int          cycle_limit = 1000000;

    clock_gen clocks (
        .clk (clk),
        .rst (rst)
    );

    block_framer UUT (
        .clk             (clk),
        .rst             (rst),
        .bdi             (bdi),
        .bdi_valid       (bdi_valid),
        .bdi_ready       (bdi_ready),
        .bdi_valid_bytes (bdi_valid_bytes),
        .bdi_pad_loc     (bdi_pad_loc),
        .bdi_eot         (bdi_eot),
        .bdi_eoi         (bdi_eoi),
        .bdi_type        (bdi_type),
        .bdo             (bdo),
        .bdo_valid       (bdo_valid),
        .bdo_ready       (bdo_ready),
        .bdo_valid_bytes (bdo_valid_bytes),
        .bdo_dsinfo      (bdo_dsinfo),
        .end_of_block    (end_of_block)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [1:0] expected_domain(input seg_type_t t);
        if (t == HDR_NPUB)
            return 2'd1;
        if (t == HDR_AD || t == HDR_HASH_MSG)
            return 2'd2;
        return 2'd3;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic word_check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic mask_check(input string name, input bytes_t got, input bytes_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic dsinfo_check(input string name, input dsinfo_t got, input dsinfo_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Stimulus table and reference model
    // --------------------------------------------------
    task automatic load_table();
        rows[0] = '{HDR_AD,       16, 1'b0, 1'b0, 1};
        rows[1] = '{HDR_PT,        6, 1'b1, 1'b0, 1};
        rows[2] = '{HDR_NPUB,      8, 1'b0, 1'b0, 1};
        rows[3] = '{HDR_HASH_MSG, 40, 1'b0, 1'b0, 3};
        rows[4] = '{HDR_AD,       13, 1'b0, 1'b1, 1};
        rows[5] = '{HDR_CT,       20, 1'b1, 1'b1, 2};
        rows[6] = '{HDR_TAG,       4, 1'b0, 1'b1, 1};
        rows[7] = '{HDR_HASH_MSG, 35, 1'b1, 1'b1, 3};
        rows[8] = '{HDR_PT,       32, 1'b1, 1'b1, 2};
        rows[9] = '{HDR_NPUB,     12, 1'b0, 1'b1, 1};
    endtask

    // Input words of one segment and the output words they should produce
    task automatic build_segment(input row_t r);
        int        nwords;
        int        nb;
        logic      last_in_blk;
        in_word_t  iw;
        exp_word_t ew;
        nwords = (r.len + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
            nb = r.len - 4 * w;
            if (nb > 4)
                nb = 4;
            iw = '0;
            ew = '0;
            for (int lane = 0; lane < 4; lane++) begin
                data_rng = lcg_next(data_rng);
                iw.data[31-8*lane -: 8] = data_rng[31:24];
                if (lane < nb) begin
                    iw.valid_bytes[3-lane] = 1'b1;
                    ew.data[31-8*lane -: 8] = data_rng[31:24];
                end else if (lane == nb) begin
                    iw.pad_loc[3-lane] = 1'b1;
                    ew.data[31-8*lane -: 8] = 8'h01;
                end
            end
            iw.eot      = (w == nwords - 1);
            iw.eoi      = iw.eot && r.eoi;
            iw.seg_type = r.seg_type;
            last_in_blk = iw.eot || (w % 4 == 3);
            ew.mask     = (last_in_blk && iw.eot) ? iw.valid_bytes : 4'hF;
            ew.eob      = last_in_blk;
            if (last_in_blk && iw.eot) begin
                ew.dsinfo.domain     = expected_domain(r.seg_type);
                ew.dsinfo.final_flag = r.eoi;
                ew.dsinfo.pad        = (nb < 4) || (w % 4 != 3);
            end
            in_q.push_back(iw);
            exp_q.push_back(ew);
        end
    endtask

    task automatic drive_word(input in_word_t iw, input logic gaps);
        int gap;
        if (gaps) begin
            stall_rng = lcg_next(stall_rng);
            if (stall_rng[31:30] == 2'b00) begin
                bdi_valid <= 1'b0;
                gap = int'(stall_rng[29:28]) + 1;
                repeat (gap) @(posedge clk);
            end
        end
        bdi             <= iw.data;
        bdi_valid       <= 1'b1;
        bdi_valid_bytes <= iw.valid_bytes;
        bdi_pad_loc     <= iw.pad_loc;
        bdi_eot         <= iw.eot;
        bdi_eoi         <= iw.eoi;
        bdi_type        <= iw.seg_type;
        @(posedge clk);
        while (!bdi_ready)
            @(posedge clk);
    endtask

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst)
            bdo_ready <= 1'b0;
        else if (ready_stall) begin
            ready_rng = lcg_next(ready_rng);
            bdo_ready <= (ready_rng[31:29] > 3'd2);
        end else
            bdo_ready <= 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && bdo_valid && bdo_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Output word %h at %0t was not expected by the model", bdo, $time);
            end else begin
                head = exp_q.pop_front();
                word_check("bdo", bdo, head.data);
                mask_check("bdo_valid_bytes", bdo_valid_bytes, head.mask);
                dsinfo_check("bdo_dsinfo", bdo_dsinfo, head.dsinfo);
                flag_check("end_of_block", end_of_block, head.eob);
                if (end_of_block)
                    blocks_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d output words still missing",
                cycles, exp_q.size());
            $display("Something failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        bdi             = '0;
        bdi_valid       = 1'b0;
        bdi_valid_bytes = '0;
        bdi_pad_loc     = '0;
        bdi_eot         = 1'b0;
        bdi_eoi         = 1'b0;
        bdi_type        = '0;

        load_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_bytes     += rows[r].len;
            blocks_expected += rows[r].blocks;
        end
        cycle_limit = total_bytes * STALL_FACTOR + OVERHEAD;

        @(posedge clk);
        while (rst)
            @(posedge clk);
        flag_check("bdi_ready after reset", bdi_ready, 1'b0);
        flag_check("bdo_valid after reset", bdo_valid, 1'b0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            build_segment(rows[r]);
            ready_stall <= rows[r].stall;
            while (in_q.size() != 0)
                drive_word(in_q.pop_front(), rows[r].stall);
        end
        bdi_valid <= 1'b0;
        bdi_eot   <= 1'b0;
        bdi_eoi   <= 1'b0;

        while (exp_q.size() != 0)
            @(posedge clk);
        // Extra words would show up here
        repeat (20) @(posedge clk);

        if (blocks_seen != blocks_expected) begin
            other_errors++;
            $display("Saw %0d output blocks but the table calls for %0d",
                blocks_seen, blocks_expected);
        end

        $display("Finished with %0d value mismatches and %0d other errors",
            check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);
    localparam time HALF_PERIOD = 10ns;
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Synchronous reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
